// File: rtl/trdb_pkg.sv
////////////////////////////////////////
// trace encoder widths, vector types,
// packet formats and privilege encoding
////////////////////////////////////////
package trdb_pkg;

    // core interface widths
    localparam int XLEN      = 32;
    localparam int CAUSE_LEN = 5;
    localparam int PRIV_LEN  = 2;
    localparam int INST_LEN  = 32;

    // branch map geometry
    localparam int BRANCH_MAP_LEN   = 31;
    localparam int BRANCH_COUNT_LEN = 5;

    // packet fields
    localparam int PAYLOAD_LEN = 80;
    localparam int P_LEN       = 4;

    // qualified instructions between forced syncs
    localparam int RESYNC_MAX     = 64;
    localparam int RESYNC_CNT_LEN = $clog2(RESYNC_MAX) + 1;

    typedef logic [XLEN-1:0]             addr_t;
    typedef logic [CAUSE_LEN-1:0]        cause_t;
    typedef logic [PRIV_LEN-1:0]         priv_t;
    typedef logic [INST_LEN-1:0]         inst_t;
    typedef logic [BRANCH_MAP_LEN-1:0]   branch_map_t;
    typedef logic [BRANCH_COUNT_LEN-1:0] branch_count_t;
    typedef logic [PAYLOAD_LEN-1:0]      payload_t;
    typedef logic [P_LEN-1:0]            plen_t;

    // major opcodes and full words for discontinuity decode
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam inst_t      INST_MRET  = 32'h3020_0073;
    localparam inst_t      INST_SRET  = 32'h1020_0073;

    // payload length in bytes per packet kind
    localparam plen_t LEN_SYNC_START     = 4'd5;
    localparam plen_t LEN_SYNC_EXCEPTION = 4'd9;
    localparam plen_t LEN_ADDR_ONLY      = 4'd9;
    localparam plen_t LEN_BRANCH_FULL    = 4'd5;

    typedef enum logic [1:0] {
        F_NONE        = 2'd0,
        F_BRANCH_FULL = 2'd1,
        F_ADDR_ONLY   = 2'd2,
        F_SYNC        = 2'd3
    } trdb_format_e;

    typedef enum logic {
        SF_START     = 1'b0,
        SF_EXCEPTION = 1'b1
    } trdb_sync_subformat_e;

    typedef enum logic [1:0] {
        PRIV_LVL_U  = 2'b00,
        PRIV_LVL_S  = 2'b01,
        PRIV_LVL_VS = 2'b10,
        PRIV_LVL_M  = 2'b11
    } priv_lvl_e;

endpackage

// File: rtl/trdb_stage_window.sv
////////////////////////////////////////
// input sampling, cause/tval select and
// nc/tc/lc instruction window
////////////////////////////////////////
`timescale 1ns/1ns

module trdb_stage_window (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             advance_i,
    input  logic             inst_valid_i,
    input  logic             trace_enable_i,
    input  logic             exception_i,
    input  logic             interrupt_i,
    input  trdb_pkg::priv_t  priv_lvl_i,
    input  trdb_pkg::inst_t  inst_data_i,
    input  trdb_pkg::addr_t  pc_i,
    input  trdb_pkg::cause_t ucause_i,
    input  trdb_pkg::cause_t scause_i,
    input  trdb_pkg::cause_t vscause_i,
    input  trdb_pkg::cause_t mcause_i,
    input  trdb_pkg::addr_t  utval_i,
    input  trdb_pkg::addr_t  stval_i,
    input  trdb_pkg::addr_t  vstval_i,
    input  trdb_pkg::addr_t  mtval_i,
    input  logic             updiscon_i,
    output logic             tc_valid_o,
    output logic             nc_valid_o,
    output trdb_pkg::addr_t  tc_iaddr_o,
    output trdb_pkg::addr_t  nc_iaddr_o,
    output trdb_pkg::inst_t  tc_inst_o,
    output trdb_pkg::priv_t  tc_priv_o,
    output logic             tc_exception_o,
    output logic             tc_interrupt_o,
    output trdb_pkg::cause_t tc_cause_o,
    output trdb_pkg::addr_t  tc_tval_o,
    output logic             first_qualified_o,
    output logic             privchange_o,
    output logic             lc_updiscon_o
);
    import trdb_pkg::*;

    cause_t cause_sel;
    addr_t  tval_sel;
    logic   qualified;
    // set while enable is low, start of trace pending
    logic   first_pending_q;
    logic   nc_valid_q;
    logic   nc_first_q;
    logic   tc_valid_q;
    logic   tc_first_q;
    logic   tc_privchange_q;
    logic   lc_updiscon_q;
    // instruction payload per stage
    addr_t  nc_iaddr_q;
    addr_t  tc_iaddr_q;
    inst_t  nc_inst_q;
    inst_t  tc_inst_q;
    priv_t  nc_priv_q;
    priv_t  tc_priv_q;
    logic   nc_exception_q;
    logic   tc_exception_q;
    logic   nc_interrupt_q;
    logic   tc_interrupt_q;
    cause_t nc_cause_q;
    cause_t tc_cause_q;
    addr_t  nc_tval_q;
    addr_t  tc_tval_q;

    assign qualified = inst_valid_i && trace_enable_i;

    // cause and tval of the current privilege
    always_comb begin
        cause_sel = ucause_i;
        tval_sel  = utval_i;
        case (priv_lvl_e'(priv_lvl_i))
            PRIV_LVL_M: begin
                cause_sel = mcause_i;
                tval_sel  = mtval_i;
            end
            PRIV_LVL_VS: begin
                cause_sel = vscause_i;
                tval_sel  = vstval_i;
            end
            PRIV_LVL_S: begin
                cause_sel = scause_i;
                tval_sel  = stval_i;
            end
            PRIV_LVL_U: begin
                cause_sel = ucause_i;
                tval_sel  = utval_i;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            first_pending_q <= 1'b1;
            nc_valid_q      <= 1'b0;
            nc_first_q      <= 1'b0;
            tc_valid_q      <= 1'b0;
            tc_first_q      <= 1'b0;
            tc_privchange_q <= 1'b0;
            lc_updiscon_q   <= 1'b0;
        end else if (advance_i) begin
            nc_valid_q <= qualified;
            nc_first_q <= qualified && first_pending_q;
            // enable low re-arms the start packet
            if (!trace_enable_i) begin
                first_pending_q <= 1'b1;
            end else if (inst_valid_i) begin
                first_pending_q <= 1'b0;
            end
            // window moves one step per qualified instruction
            if (nc_valid_q) begin
                tc_valid_q      <= 1'b1;
                tc_first_q      <= nc_first_q;
                tc_privchange_q <= tc_valid_q && (nc_priv_q != tc_priv_q);
                lc_updiscon_q   <= updiscon_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_i && qualified) begin
            nc_iaddr_q     <= pc_i;
            nc_inst_q      <= inst_data_i;
            nc_priv_q      <= priv_lvl_i;
            nc_exception_q <= exception_i;
            nc_interrupt_q <= interrupt_i;
            nc_cause_q     <= cause_sel;
            nc_tval_q      <= tval_sel;
        end
        if (advance_i && nc_valid_q) begin
            tc_iaddr_q     <= nc_iaddr_q;
            tc_inst_q      <= nc_inst_q;
            tc_priv_q      <= nc_priv_q;
            tc_exception_q <= nc_exception_q;
            tc_interrupt_q <= nc_interrupt_q;
            tc_cause_q     <= nc_cause_q;
            tc_tval_q      <= nc_tval_q;
        end
    end

    assign tc_valid_o        = tc_valid_q;
    assign nc_valid_o        = nc_valid_q;
    assign tc_iaddr_o        = tc_iaddr_q;
    assign nc_iaddr_o        = nc_iaddr_q;
    assign tc_inst_o         = tc_inst_q;
    assign tc_priv_o         = tc_priv_q;
    assign tc_exception_o    = tc_exception_q;
    assign tc_interrupt_o    = tc_interrupt_q;
    assign tc_cause_o        = tc_cause_q;
    assign tc_tval_o         = tc_tval_q;
    assign first_qualified_o = tc_first_q;
    assign privchange_o      = tc_privchange_q;
    assign lc_updiscon_o     = lc_updiscon_q;

endmodule

// File: rtl/trdb_itype_detector.sv
////////////////////////////////////////
// branch, taken and uninferable jump decode
////////////////////////////////////////
`timescale 1ns/1ns

module trdb_itype_detector (
    input  logic            tc_valid_i,
    input  logic            nc_valid_i,
    input  trdb_pkg::inst_t tc_inst_i,
    input  trdb_pkg::addr_t tc_iaddr_i,
    input  trdb_pkg::addr_t nc_iaddr_i,
    output logic            branch_o,
    output logic            branch_taken_o,
    output logic            updiscon_o
);
    import trdb_pkg::*;

    logic [6:0] opcode;
    // fall-through address, no compressed instructions
    addr_t      seq_iaddr;
    logic       is_xret;

    assign opcode    = tc_inst_i[6:0];
    assign seq_iaddr = tc_iaddr_i + XLEN'(4);
    assign is_xret   = (tc_inst_i == INST_MRET) || (tc_inst_i == INST_SRET);

    // outcome only known once nc holds the successor
    assign branch_o       = tc_valid_i && nc_valid_i && (opcode == OPC_BRANCH);
    assign branch_taken_o = branch_o && (nc_iaddr_i != seq_iaddr);

    // target not recoverable from the binary
    assign updiscon_o = tc_valid_i && ((opcode == OPC_JALR) || is_xret);

endmodule

// File: rtl/trdb_branch_map.sv
////////////////////////////////////////
// branch outcome map with count and flush
////////////////////////////////////////
`timescale 1ns/1ns

module trdb_branch_map (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    advance_i,
    input  logic                    valid_i,
    input  logic                    taken_i,
    input  logic                    flush_i,
    input  logic                    keep_current_i,
    output trdb_pkg::branch_map_t   map_o,
    output trdb_pkg::branch_count_t count_o,
    output logic                    full_o
);
    import trdb_pkg::*;

    // oldest branch in bit 0, taken = 1
    branch_map_t   map_q;
    branch_count_t count_q;
    logic          keep;

    // current outcome opens the next map unless the flush is a sync
    assign keep = valid_i && keep_current_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (advance_i) begin
            if (flush_i) begin
                map_q   <= branch_map_t'(keep && taken_i);
                count_q <= branch_count_t'(keep);
            end else if (valid_i) begin
                map_q[count_q] <= taken_i;
                count_q        <= count_q + 1'b1;
            end
        end
    end

    assign map_o   = map_q;
    assign count_o = count_q;
    // all slots used, next decision must report
    assign full_o  = (count_q == BRANCH_COUNT_LEN'(BRANCH_MAP_LEN));

endmodule

// File: rtl/trdb_resync_counter.sv
////////////////////////////////////////
// periodic resync request counter
////////////////////////////////////////
`timescale 1ns/1ns

module trdb_resync_counter (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic advance_i,
    input  logic qualified_i,
    input  logic restart_i,
    output logic resync_due_o
);
    import trdb_pkg::*;

    // decided instructions, the sync itself counts as one
    logic [RESYNC_CNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (advance_i && qualified_i) begin
            if (restart_i) begin
                count_q <= RESYNC_CNT_LEN'(1);
            end else if (!resync_due_o) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // saturates, stays due until a sync restarts it
    assign resync_due_o = (count_q == RESYNC_CNT_LEN'(RESYNC_MAX));

endmodule

// File: rtl/trdb_priority.sv
////////////////////////////////////////
// packet format decision for tc
////////////////////////////////////////
`timescale 1ns/1ns

module trdb_priority (
    input  logic                           tc_valid_i,
    input  logic                           nc_valid_i,
    input  logic                           first_qualified_i,
    input  logic                           exception_i,
    input  logic                           resync_due_i,
    input  logic                           lc_updiscon_i,
    input  logic                           privchange_i,
    input  logic                           map_full_i,
    output logic                           decide_o,
    output trdb_pkg::trdb_format_e         format_o,
    output trdb_pkg::trdb_sync_subformat_e subformat_o,
    output logic                           flush_o,
    output logic                           keep_current_o,
    output logic                           resync_restart_o
);
    import trdb_pkg::*;

    // tc is decided once its successor sits in nc
    assign decide_o = tc_valid_i && nc_valid_i;

    // first matching rule wins
    always_comb begin
        format_o    = F_NONE;
        subformat_o = SF_START;
        if (decide_o) begin
            if (first_qualified_i) begin
                format_o = F_SYNC;
            end else if (exception_i) begin
                format_o    = F_SYNC;
                subformat_o = SF_EXCEPTION;
            end else if (resync_due_i) begin
                format_o = F_SYNC;
            end else if (lc_updiscon_i) begin
                format_o = F_ADDR_ONLY;
            end else if (privchange_i) begin
                format_o = F_SYNC;
            end else if (map_full_i) begin
                format_o = F_BRANCH_FULL;
            end
        end
    end

    // every packet empties the map
    assign flush_o          = (format_o != F_NONE);
    // a sync drops tc's outcome, map packets carry it into the next map
    assign keep_current_o   = (format_o == F_ADDR_ONLY) || (format_o == F_BRANCH_FULL);
    assign resync_restart_o = (format_o == F_SYNC);

endmodule

// File: rtl/trdb_packet_emitter.sv
////////////////////////////////////////
// payload packing, byte length and
// single packet hold for back-pressure
////////////////////////////////////////
`timescale 1ns/1ns

module trdb_packet_emitter (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           decide_i,
    input  trdb_pkg::trdb_format_e         format_i,
    input  trdb_pkg::trdb_sync_subformat_e subformat_i,
    input  trdb_pkg::addr_t                iaddr_i,
    input  trdb_pkg::priv_t                priv_i,
    input  trdb_pkg::cause_t               cause_i,
    input  logic                           interrupt_i,
    input  trdb_pkg::addr_t                tval_i,
    input  trdb_pkg::branch_map_t          map_i,
    input  trdb_pkg::branch_count_t        count_i,
    input  logic                           encapsulator_ready_i,
    output logic                           advance_o,
    output logic                           stall_o,
    output logic                           packet_valid_o,
    output trdb_pkg::trdb_format_e         packet_format_o,
    output trdb_pkg::trdb_sync_subformat_e packet_subformat_o,
    output trdb_pkg::plen_t                packet_length_o,
    output trdb_pkg::payload_t             packet_payload_o
);
    import trdb_pkg::*;

    logic                 emit;
    payload_t             payload_d;
    plen_t                length_d;
    logic                 valid_q;
    trdb_format_e         format_q;
    trdb_sync_subformat_e subformat_q;
    plen_t                length_q;
    payload_t             payload_q;

    assign emit = decide_i && (format_i != F_NONE);

    // slot free or leaving this cycle
    assign advance_o = !valid_q || encapsulator_ready_i;
    assign stall_o   = valid_q && !encapsulator_ready_i;

    // fields packed from bit 0 upwards, unused bits zero
    always_comb begin
        payload_d = '0;
        length_d  = '0;
        case (format_i)
            F_SYNC: begin
                if (subformat_i == SF_EXCEPTION) begin
                    payload_d[2*XLEN+CAUSE_LEN:0] = {tval_i, iaddr_i, interrupt_i, cause_i};
                    length_d = LEN_SYNC_EXCEPTION;
                end else begin
                    payload_d[XLEN+PRIV_LEN-1:0] = {iaddr_i, priv_i};
                    length_d = LEN_SYNC_START;
                end
            end
            F_ADDR_ONLY: begin
                payload_d[XLEN+BRANCH_COUNT_LEN+BRANCH_MAP_LEN-1:0] = {iaddr_i, count_i, map_i};
                length_d = LEN_ADDR_ONLY;
            end
            F_BRANCH_FULL: begin
                payload_d[BRANCH_COUNT_LEN+BRANCH_MAP_LEN-1:0] = {count_i, map_i};
                length_d = LEN_BRANCH_FULL;
            end
            default: begin
                length_d = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (advance_o) begin
            valid_q <= emit;
        end
    end

    // held stable until accepted
    always_ff @(posedge clk_i) begin
        if (advance_o && emit) begin
            format_q    <= format_i;
            subformat_q <= subformat_i;
            length_q    <= length_d;
            payload_q   <= payload_d;
        end
    end

    assign packet_valid_o     = valid_q;
    assign packet_format_o    = format_q;
    assign packet_subformat_o = subformat_q;
    assign packet_length_o    = length_q;
    assign packet_payload_o   = payload_q;

endmodule

// File: rtl/trace_debugger.sv
////////////////////////////////////////
// trace encoder top level
////////////////////////////////////////
`timescale 1ns/1ns

module trace_debugger (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           inst_valid_i,
    input  logic                           trace_enable_i,
    input  logic                           exception_i,
    input  logic                           interrupt_i,
    input  trdb_pkg::priv_t                priv_lvl_i,
    input  trdb_pkg::inst_t                inst_data_i,
    input  trdb_pkg::addr_t                pc_i,
    input  trdb_pkg::cause_t               ucause_i,
    input  trdb_pkg::cause_t               scause_i,
    input  trdb_pkg::cause_t               vscause_i,
    input  trdb_pkg::cause_t               mcause_i,
    input  trdb_pkg::addr_t                utval_i,
    input  trdb_pkg::addr_t                stval_i,
    input  trdb_pkg::addr_t                vstval_i,
    input  trdb_pkg::addr_t                mtval_i,
    input  logic                           encapsulator_ready_i,
    output logic                           packet_valid_o,
    output trdb_pkg::trdb_format_e         packet_format_o,
    output trdb_pkg::trdb_sync_subformat_e packet_subformat_o,
    output trdb_pkg::plen_t                packet_length_o,
    output trdb_pkg::payload_t             packet_payload_o,
    output logic                           stall_o
);
    import trdb_pkg::*;

    // global enable for every unit register
    logic                 advance;
    // window
    logic                 tc_valid;
    logic                 nc_valid;
    addr_t                tc_iaddr;
    addr_t                nc_iaddr;
    inst_t                tc_inst;
    priv_t                tc_priv;
    logic                 tc_exception;
    logic                 tc_interrupt;
    cause_t               tc_cause;
    addr_t                tc_tval;
    logic                 first_qualified;
    logic                 privchange;
    logic                 lc_updiscon;
    // decode and state
    logic                 updiscon;
    logic                 branch;
    logic                 branch_taken;
    branch_map_t          branch_map;
    branch_count_t        branch_count;
    logic                 map_full;
    logic                 resync_due;
    // decision
    logic                 decide;
    trdb_format_e         format;
    trdb_sync_subformat_e subformat;
    logic                 map_flush;
    logic                 keep_current;
    logic                 resync_restart;

    trdb_stage_window i_stage_window (
        .clk_i(clk_i), .rst_ni(rst_ni), .advance_i(advance),
        .inst_valid_i(inst_valid_i), .trace_enable_i(trace_enable_i),
        .exception_i(exception_i), .interrupt_i(interrupt_i),
        .priv_lvl_i(priv_lvl_i), .inst_data_i(inst_data_i), .pc_i(pc_i),
        .ucause_i(ucause_i), .scause_i(scause_i), .vscause_i(vscause_i), .mcause_i(mcause_i),
        .utval_i(utval_i), .stval_i(stval_i), .vstval_i(vstval_i), .mtval_i(mtval_i),
        .updiscon_i(updiscon),
        .tc_valid_o(tc_valid), .nc_valid_o(nc_valid),
        .tc_iaddr_o(tc_iaddr), .nc_iaddr_o(nc_iaddr),
        .tc_inst_o(tc_inst), .tc_priv_o(tc_priv),
        .tc_exception_o(tc_exception), .tc_interrupt_o(tc_interrupt),
        .tc_cause_o(tc_cause), .tc_tval_o(tc_tval),
        .first_qualified_o(first_qualified), .privchange_o(privchange),
        .lc_updiscon_o(lc_updiscon)
    );

    trdb_itype_detector i_itype_detector (
        .tc_valid_i(tc_valid), .nc_valid_i(nc_valid), .tc_inst_i(tc_inst),
        .tc_iaddr_i(tc_iaddr), .nc_iaddr_i(nc_iaddr),
        .branch_o(branch), .branch_taken_o(branch_taken), .updiscon_o(updiscon)
    );

    trdb_branch_map i_branch_map (
        .clk_i(clk_i), .rst_ni(rst_ni), .advance_i(advance),
        .valid_i(branch), .taken_i(branch_taken),
        .flush_i(map_flush), .keep_current_i(keep_current),
        .map_o(branch_map), .count_o(branch_count), .full_o(map_full)
    );

    trdb_resync_counter i_resync_counter (
        .clk_i(clk_i), .rst_ni(rst_ni), .advance_i(advance),
        .qualified_i(decide), .restart_i(resync_restart), .resync_due_o(resync_due)
    );

    trdb_priority i_priority (
        .tc_valid_i(tc_valid), .nc_valid_i(nc_valid),
        .first_qualified_i(first_qualified), .exception_i(tc_exception),
        .resync_due_i(resync_due), .lc_updiscon_i(lc_updiscon),
        .privchange_i(privchange), .map_full_i(map_full),
        .decide_o(decide), .format_o(format), .subformat_o(subformat),
        .flush_o(map_flush), .keep_current_o(keep_current),
        .resync_restart_o(resync_restart)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .decide_i(decide), .format_i(format), .subformat_i(subformat),
        .iaddr_i(tc_iaddr), .priv_i(tc_priv), .cause_i(tc_cause),
        .interrupt_i(tc_interrupt), .tval_i(tc_tval),
        .map_i(branch_map), .count_i(branch_count),
        .encapsulator_ready_i(encapsulator_ready_i),
        .advance_o(advance), .stall_o(stall_o),
        .packet_valid_o(packet_valid_o), .packet_format_o(packet_format_o),
        .packet_subformat_o(packet_subformat_o), .packet_length_o(packet_length_o),
        .packet_payload_o(packet_payload_o)
    );

endmodule

// File: include/tb_trace_table.svh
////////////////////////////////////////
// stimulus rows and expected packets
// for the trace encoder testbench
////////////////////////////////////////
`ifndef TB_TRACE_TABLE_SVH
`define TB_TRACE_TABLE_SVH

// instruction words used by the rows
localparam logic [31:0] I_NOP  = 32'h0000_0013;
localparam logic [31:0] I_BEQ  = 32'h0000_0063;
localparam logic [31:0] I_JALR = 32'h0000_8067;
localparam logic [31:0] I_MRET = 32'h3020_0073;

// per privilege trap state, held constant on the core side
localparam logic [4:0]  UCAUSE  = 5'h08;
localparam logic [4:0]  SCAUSE  = 5'h09;
localparam logic [4:0]  VSCAUSE = 5'h0a;
localparam logic [4:0]  MCAUSE  = 5'h0b;
localparam logic [31:0] UTVAL   = 32'h0bad_0001;
localparam logic [31:0] STVAL   = 32'h5555_0002;
localparam logic [31:0] VSTVAL  = 32'h6666_0004;
localparam logic [31:0] MTVAL   = 32'hc0de_0003;

// columns: pc (0 continues from the previous row), instruction, exception,
// interrupt, privilege, enable, repeat count, taken mask (bit j for repeat j)
typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        exc;
    logic        intr;
    logic [1:0]  priv;
    logic        en;
    logic [7:0]  rep;
    logic [30:0] mask;
} row_t;

localparam int N_ROWS = 13;
localparam int N_INST = 70;

localparam row_t ROWS [N_ROWS] = '{
    '{32'h0000_1000, I_NOP,  1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_1004, I_NOP,  1'b1, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_2000, I_NOP,  1'b1, 1'b1, 2'b00, 1'b1, 8'd1,  31'h0},
    '{32'h0000_3000, I_NOP,  1'b0, 1'b0, 2'b00, 1'b1, 8'd1,  31'h0},
    '{32'h0000_3004, I_NOP,  1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    // taken, successor skips one word
    '{32'h0000_3008, I_BEQ,  1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_3010, I_BEQ,  1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_3014, I_JALR, 1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_4000, I_NOP,  1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_4004, I_MRET, 1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    '{32'h0000_5000, I_NOP,  1'b0, 1'b0, 2'b11, 1'b1, 8'd1,  31'h0},
    // 31 branches fill the map
    '{32'h0000_0000, I_BEQ,  1'b0, 1'b0, 2'b11, 1'b1, 8'd31, 31'h2a5a_c3f1},
    // filler up to the periodic resync at 0x5128
    '{32'h0000_0000, I_NOP,  1'b0, 1'b0, 2'b11, 1'b1, 8'd28, 31'h0}
};

// columns: format, subformat, byte length, payload
typedef struct packed {
    logic [1:0]  fmt;
    logic        sub;
    logic [3:0]  len;
    logic [79:0] payload;
} pkt_t;

localparam int N_EXP = 8;

localparam pkt_t EXP [N_EXP] = '{
    '{2'd3, 1'b0, 4'd5, 80'({32'h0000_1000, 2'b11})},
    '{2'd3, 1'b1, 4'd9, 80'({MTVAL, 32'h0000_1004, 1'b0, MCAUSE})},
    '{2'd3, 1'b1, 4'd9, 80'({UTVAL, 32'h0000_2000, 1'b1, UCAUSE})},
    '{2'd3, 1'b0, 4'd5, 80'({32'h0000_3004, 2'b11})},
    '{2'd2, 1'b0, 4'd9, 80'({32'h0000_4000, 5'd2, 31'h1})},
    '{2'd2, 1'b0, 4'd9, 80'({32'h0000_5000, 5'd0, 31'h0})},
    '{2'd1, 1'b0, 4'd5, 80'({5'd31, 31'h2a5a_c3f1})},
    '{2'd3, 1'b0, 4'd5, 80'({32'h0000_5128, 2'b11})}
};

`endif

// File: sim/tb_trace_debugger.sv
////////////////////////////////////////
// trace encoder testbench with table
// stimulus and random back-pressure
////////////////////////////////////////
`timescale 1ns/1ns

module tb_trace_debugger;
    import trdb_pkg::*;

    `include "tb_trace_table.svh"

    // worst stall per instruction and packet, in cycles
    localparam int STALL_BOUND = 40;
    localparam int TIMEOUT     = 16 + (N_INST + N_EXP) * STALL_BOUND + 100;

    logic        clk_i;
    logic        rst_ni;
    logic        inst_valid_i;
    logic        trace_enable_i;
    logic        exception_i;
    logic        interrupt_i;
    priv_t       priv_lvl_i;
    inst_t       inst_data_i;
    addr_t       pc_i;
    logic        encapsulator_ready_i;
    logic        packet_valid_o;
    trdb_format_e         packet_format_o;
    trdb_sync_subformat_e packet_subformat_o;
    plen_t       packet_length_o;
    payload_t    packet_payload_o;
    logic        stall_o;
    logic [31:0] lcg_state;
    int          exp_idx;
    int          cycles;

    trace_debugger dut_i (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .inst_valid_i(inst_valid_i), .trace_enable_i(trace_enable_i),
        .exception_i(exception_i), .interrupt_i(interrupt_i),
        .priv_lvl_i(priv_lvl_i), .inst_data_i(inst_data_i), .pc_i(pc_i),
        .ucause_i(UCAUSE), .scause_i(SCAUSE), .vscause_i(VSCAUSE), .mcause_i(MCAUSE),
        .utval_i(UTVAL), .stval_i(STVAL), .vstval_i(VSTVAL), .mtval_i(MTVAL),
        .encapsulator_ready_i(encapsulator_ready_i),
        .packet_valid_o(packet_valid_o), .packet_format_o(packet_format_o),
        .packet_subformat_o(packet_subformat_o), .packet_length_o(packet_length_o),
        .packet_payload_o(packet_payload_o), .stall_o(stall_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // one clock, then new ready level, inputs settle after it
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
        lcg_state = lcg_next(lcg_state);
        // ready high about three times in four
        encapsulator_ready_i = (lcg_state[17:16] != 2'b00);
        #1;
    endtask

    task automatic issue_row(input row_t row, input logic [31:0] pc);
        next_cycle();
        // hold off the core while a packet is stuck
        while (stall_o) begin
            inst_valid_i = 1'b0;
            next_cycle();
        end
        pc_i           = pc;
        inst_data_i    = row.inst;
        exception_i    = row.exc;
        interrupt_i    = row.intr;
        priv_lvl_i     = row.priv;
        trace_enable_i = row.en;
        inst_valid_i   = 1'b1;
    endtask

    // packet and stall monitor, sampled at the edge
    always @(posedge clk_i) begin
        if (rst_ni) begin
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                $display("timeout: only %0d of %0d packets seen", exp_idx, N_EXP);
                $display("sim failed");
                $fatal(1);
            end
            check_value("stall_o", 80'(stall_o),
                        80'(packet_valid_o && !encapsulator_ready_i));
            if (packet_valid_o && encapsulator_ready_i) begin
                if (exp_idx >= N_EXP) begin
                    $display("extra packet accepted after the last expected one");
                    $display("sim failed");
                    $fatal(1);
                end else begin
                    check_value("packet_format_o", 80'(packet_format_o), 80'(EXP[exp_idx].fmt));
                    check_value("packet_subformat_o", 80'(packet_subformat_o),
                                80'(EXP[exp_idx].sub));
                    check_value("packet_length_o", 80'(packet_length_o), 80'(EXP[exp_idx].len));
                    check_value("packet_payload_o", packet_payload_o, EXP[exp_idx].payload);
                    exp_idx = exp_idx + 1;
                end
            end
        end
    end

    initial begin
        logic [31:0] cur_pc;
        row_t        row;
        clk_i                = 1'b0;
        rst_ni               = 1'b0;
        inst_valid_i         = 1'b0;
        trace_enable_i       = 1'b0;
        exception_i          = 1'b0;
        interrupt_i          = 1'b0;
        priv_lvl_i           = 2'b11;
        inst_data_i          = '0;
        pc_i                 = '0;
        encapsulator_ready_i = 1'b0;
        lcg_state            = 32'd61068;
        exp_idx              = 0;
        cycles               = 0;
        cur_pc               = '0;
        repeat (16) @(posedge clk_i);
        #3;
        rst_ni = 1'b1;
        // expand rows, taken branches skip one word
        for (int r = 0; r < N_ROWS; r++) begin
            row = ROWS[r];
            if (row.pc != 32'h0) begin
                cur_pc = row.pc;
            end
            for (int j = 0; j < int'(row.rep); j++) begin
                issue_row(row, cur_pc);
                cur_pc = cur_pc + (row.mask[j] ? 32'd8 : 32'd4);
            end
        end
        next_cycle();
        inst_valid_i = 1'b0;
        while (exp_idx < N_EXP) begin
            next_cycle();
        end
        // room for a stray extra packet
        repeat (8) next_cycle();
        if (exp_idx == N_EXP) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/trdb_pkg.sv
rtl/trdb_stage_window.sv
rtl/trdb_itype_detector.sv
rtl/trdb_branch_map.sv
rtl/trdb_resync_counter.sv
rtl/trdb_priority.sv
rtl/trdb_packet_emitter.sv
rtl/trace_debugger.sv
sim/tb_trace_debugger.sv

// File: run.sh
#!/bin/sh
verilator --binary -f tb.f --top-module tb_trace_debugger -o tb_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
